//--- verilog/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry: 8 sets of two ways, one 32-bit word per line
`define CACHE_SETS      8
`define CACHE_SET_BITS  3
`define CACHE_TAG_BITS  27  // 32 - set bits - 2 byte-offset bits

// Word that always goes straight to memory
`define CACHE_UNCACHED_ADDR 32'h000000FC

`endif

//--- verilog/cachePkg.sv
`include "cache_defs.svh"
`default_nettype none

package cachePkg;

    // funct3 width codes. The load and the store of one width share a code,
    // so cacheReqS.write tells lb from sb, lh from sh and lw from sw
    typedef enum logic [2:0] {
        accByte  = 3'b000,  // lb / sb
        accHalf  = 3'b001,  // lh / sh
        accWord  = 3'b010,  // lw / sw
        accByteU = 3'b100,  // lbu
        accHalfU = 3'b101   // lhu
    } accessE;

    typedef enum logic [2:0] {
        missIdle,
        missLookup,
        missWriteBack,
        missRefill,
        missBypass,
        missDone
    } missStateE;

    // One CPU request as held by the decode stage
    typedef struct packed {
        logic                       write;
        accessE                     access;
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [`CACHE_SET_BITS-1:0] setIdx;
        logic [1:0]                 offset;    // Byte within the word
        logic                       uncached;
        logic [31:0]                wdata;
    } cacheReqS;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [31:0]                data;
    } wayLineS;

    // Memory-side Wishbone request, cyc and stb move together
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } memReqS;

endpackage

`default_nettype wire

//--- verilog/cacheReqDecode.sv
`timescale 1ns/10ps
`include "cache_defs.svh"
`default_nettype none

module cacheReqDecode (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpuCyc,
    input  logic               cpuStb,
    input  logic               cpuWe,
    input  logic [31:0]        cpuAdr,
    input  logic [31:0]        cpuDatW,
    input  logic [2:0]         cpuFunct3,
    input  logic               reqRetire,
    output logic               reqValid,
    output cachePkg::cacheReqS req
);

    localparam logic [31:0] UncachedAddr = `CACHE_UNCACHED_ADDR;

    cachePkg::cacheReqS nextReq;
    logic               capture;

    // Only one request in flight
    assign capture = cpuCyc && cpuStb && !reqValid;

    // Address split into tag, set and byte offset
    always_comb begin
        nextReq.write    = cpuWe;
        nextReq.access   = cachePkg::accessE'(cpuFunct3);
        nextReq.tag      = cpuAdr[31:`CACHE_SET_BITS+2];
        nextReq.setIdx   = cpuAdr[`CACHE_SET_BITS+1:2];
        nextReq.offset   = cpuAdr[1:0];
        nextReq.uncached = (cpuAdr[31:2] == UncachedAddr[31:2]);
        nextReq.wdata    = cpuDatW;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reqValid <= 1'b0;
        end else if (reqValid && reqRetire) begin
            reqValid <= 1'b0;  // Result stage has acked the CPU
        end else if (capture) begin
            reqValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req <= nextReq;
        end
    end

    // The CPU keeps its request on the bus until the ack
    assert property (@(posedge clk) disable iff (rst)
        reqValid && !reqRetire |-> cpuCyc && cpuStb && cpuWe == req.write
            && cpuAdr[31:2] == {req.tag, req.setIdx});

    // Retire only comes back for a request that is still held
    assert property (@(posedge clk) disable iff (rst)
        reqRetire |-> reqValid);

endmodule

`default_nettype wire

//--- verilog/cacheWayArray.sv
`timescale 1ns/10ps
`include "cache_defs.svh"
`default_nettype none

module cacheWayArray (
    input  logic               clk,
    input  logic               rst,
    input  logic               reqValid,
    input  cachePkg::cacheReqS req,
    output logic               lineDone,
    output logic [31:0]        lineData,
    output cachePkg::memReqS   mem,
    input  logic [31:0]        memDatR,
    input  logic               memAck
);

    cachePkg::wayLineS           lines [`CACHE_SETS][2];
    logic [`CACHE_SETS-1:0]      lru;  // Way to evict next in each set
    cachePkg::missStateE         state;

    cachePkg::wayLineS           way0;
    cachePkg::wayLineS           way1;
    cachePkg::wayLineS           victim;
    logic                        hit0;
    logic                        hit1;
    logic                        hitWay;
    logic                        victimWay;
    logic [31:0]                 hitData;
    logic [3:0]                  byteEn;
    logic [31:0]                 byteMask;
    logic [31:0]                 storeData;
    logic [31:0]                 merged;
    logic                        lookupHit;

    assign way0      = lines[req.setIdx][0];
    assign way1      = lines[req.setIdx][1];
    assign hit0      = way0.valid && (way0.tag == req.tag);
    assign hit1      = way1.valid && (way1.tag == req.tag);
    assign hitWay    = hit1;
    assign hitData   = hit1 ? way1.data : way0.data;
    assign victimWay = lru[req.setIdx];
    assign victim    = lines[req.setIdx][victimWay];
    assign lookupHit = (state == cachePkg::missLookup) && !req.uncached && (hit0 || hit1);

    // Store merge replicates the store data and picks lanes by byte enable
    always_comb begin
        case (req.access)
            cachePkg::accByte, cachePkg::accByteU: begin
                byteEn    = 4'b0001 << req.offset;
                storeData = {4{req.wdata[7:0]}};
            end
            cachePkg::accHalf, cachePkg::accHalfU: begin
                byteEn    = req.offset[1] ? 4'b1100 : 4'b0011;
                storeData = {2{req.wdata[15:0]}};
            end
            default: begin
                byteEn    = 4'b1111;
                storeData = req.wdata;
            end
        endcase
        byteMask = {{8{byteEn[3]}}, {8{byteEn[2]}}, {8{byteEn[1]}}, {8{byteEn[0]}}};
        merged   = (hitData & ~byteMask) | (storeData & byteMask);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= cachePkg::missIdle;
            lineDone <= 1'b0;
            mem      <= '0;
            lru      <= '0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                lines[s][0] <= '0;
                lines[s][1] <= '0;
            end
        end else begin
            lineDone <= 1'b0;
            case (state)
                cachePkg::missIdle: begin
                    if (reqValid) begin
                        state <= cachePkg::missLookup;
                    end
                end
                cachePkg::missLookup: begin
                    if (req.uncached) begin
                        state <= cachePkg::missBypass;
                    end else if (hit0 || hit1) begin
                        lru[req.setIdx] <= ~hitWay;
                        if (req.write) begin
                            lines[req.setIdx][hitWay].data  <= merged;
                            lines[req.setIdx][hitWay].dirty <= 1'b1;
                        end
                        lineDone <= 1'b1;
                        state    <= cachePkg::missDone;
                    end else if (victim.valid && victim.dirty) begin
                        state <= cachePkg::missWriteBack;
                    end else begin
                        state <= cachePkg::missRefill;
                    end
                end
                cachePkg::missWriteBack: begin
                    if (!mem.cyc) begin
                        mem.cyc <= 1'b1;
                        mem.we  <= 1'b1;
                        mem.adr <= {victim.tag, req.setIdx, 2'b00};
                        mem.dat <= victim.data;
                    end else if (memAck) begin
                        mem.cyc <= 1'b0;  // Idle one cycle before the refill read
                        mem.we  <= 1'b0;
                        state   <= cachePkg::missRefill;
                    end
                end
                cachePkg::missRefill: begin
                    if (!mem.cyc) begin
                        mem.cyc <= 1'b1;
                        mem.we  <= 1'b0;
                        mem.adr <= {req.tag, req.setIdx, 2'b00};
                    end else if (memAck) begin
                        mem.cyc <= 1'b0;
                        lines[req.setIdx][victimWay] <= '{valid: 1'b1, dirty: 1'b0,
                                                          tag: req.tag, data: memDatR};
                        state <= cachePkg::missLookup;  // Replays as a hit
                    end
                end
                cachePkg::missBypass: begin
                    if (!mem.cyc) begin
                        mem.cyc <= 1'b1;
                        mem.we  <= req.write;
                        mem.adr <= {req.tag, req.setIdx, 2'b00};
                        mem.dat <= req.wdata;  // sb/sh go out as whole words
                    end else if (memAck) begin
                        mem.cyc  <= 1'b0;
                        mem.we   <= 1'b0;
                        lineDone <= 1'b1;
                        state    <= cachePkg::missDone;
                    end
                end
                cachePkg::missDone: begin
                    // Wait until decode has let go of the retired request
                    if (!reqValid) begin
                        state <= cachePkg::missIdle;
                    end
                end
                default: state <= cachePkg::missIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookupHit) begin
            lineData <= hitData;
        end else if (state == cachePkg::missBypass && mem.cyc && memAck) begin
            lineData <= memDatR;
        end
    end

    // A tag lives in at most one way of its set
    assert property (@(posedge clk) disable iff (rst)
        state == cachePkg::missLookup |-> !(hit0 && hit1));

    // Wishbone master holds the request until ack
    assert property (@(posedge clk) disable iff (rst)
        mem.cyc && !memAck |=> mem.cyc && $stable(mem.adr) && $stable(mem.we));

    // One single-cycle result for a request that decode still holds
    assert property (@(posedge clk) disable iff (rst)
        lineDone |-> reqValid ##1 !lineDone);

endmodule

`default_nettype wire

//--- verilog/cacheLoadFormat.sv
`timescale 1ns/10ps
`default_nettype none

module cacheLoadFormat (
    input  logic               clk,
    input  logic               rst,
    input  logic               lineDone,
    input  logic [31:0]        lineData,
    input  cachePkg::cacheReqS req,
    output logic               cpuAck,
    output logic [31:0]        cpuDatR,
    output logic               reqRetire
);

    logic [31:0] shifted;
    logic [31:0] loadData;
    logic        ackQ;

    assign shifted = lineData >> {req.offset, 3'b000};  // Addressed byte to bit 0

    always_comb begin
        if (req.write) begin
            loadData = '0;
        end else begin
            case (req.access)
                cachePkg::accByte:  loadData = {{24{shifted[7]}}, shifted[7:0]};
                cachePkg::accByteU: loadData = {24'b0, shifted[7:0]};
                cachePkg::accHalf:  loadData = {{16{shifted[15]}}, shifted[15:0]};
                cachePkg::accHalfU: loadData = {16'b0, shifted[15:0]};
                default:            loadData = lineData;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= lineDone;
        end
    end

    always_ff @(posedge clk) begin
        if (lineDone) begin
            cpuDatR <= loadData;
        end
    end

    assign cpuAck    = ackQ;
    assign reqRetire = ackQ;  // Frees decode in the same cycle as the CPU ack

endmodule

`default_nettype wire

//--- verilog/l2Cache.sv
`timescale 1ns/10ps
`default_nettype none

module l2Cache (
    input  logic        clk,
    input  logic        rst,
    // CPU side, Wishbone classic slave
    input  logic        cpuCyc,
    input  logic        cpuStb,
    input  logic        cpuWe,
    input  logic [31:0] cpuAdr,
    input  logic [31:0] cpuDatW,
    input  logic [2:0]  cpuFunct3,
    output logic [31:0] cpuDatR,
    output logic        cpuAck,
    // Memory side, Wishbone classic master
    output logic        memCyc,
    output logic        memStb,
    output logic        memWe,
    output logic [31:0] memAdr,
    output logic [31:0] memDatW,
    input  logic [31:0] memDatR,
    input  logic        memAck
);

    logic               reqValid;
    logic               reqRetire;
    cachePkg::cacheReqS req;
    logic               lineDone;
    logic [31:0]        lineData;
    cachePkg::memReqS   mem;

    cacheReqDecode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpuCyc    (cpuCyc),
        .cpuStb    (cpuStb),
        .cpuWe     (cpuWe),
        .cpuAdr    (cpuAdr),
        .cpuDatW   (cpuDatW),
        .cpuFunct3 (cpuFunct3),
        .reqRetire (reqRetire),
        .reqValid  (reqValid),
        .req       (req)
    );

    cacheWayArray u_execute (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .lineDone (lineDone),
        .lineData (lineData),
        .mem      (mem),
        .memDatR  (memDatR),
        .memAck   (memAck)
    );

    cacheLoadFormat u_result (
        .clk       (clk),
        .rst       (rst),
        .lineDone  (lineDone),
        .lineData  (lineData),
        .req       (req),
        .cpuAck    (cpuAck),
        .cpuDatR   (cpuDatR),
        .reqRetire (reqRetire)
    );

    assign memCyc  = mem.cyc;
    assign memStb  = mem.cyc;
    assign memWe   = mem.we;
    assign memAdr  = mem.adr;  // Byte address of the word, low bits zero
    assign memDatW = mem.dat;

endmodule

`default_nettype wire

//--- verif/wbMemModel.sv
`timescale 1ns/10ps
`default_nettype none

module wbMemModel (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack
);

    logic [31:0] words [0:1023];  // 4 KB backing store
    integer      seed;
    logic        pending;
    int          waitCnt;
    int          delay;

    // Hash of the full byte address, so every word differs
    function automatic logic [31:0] patternWord(input logic [31:0] addr);
        return (addr * 32'h9E3779B1) ^ 32'h6C8E9CF5;
    endfunction

    initial begin
        seed = 32'h1ab4466f;
        for (int i = 0; i < 1024; i++) begin
            words[i] = patternWord(i * 4);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack     <= 1'b0;
            pending <= 1'b0;
            waitCnt <= 0;
            datR    <= '0;
        end else if (ack) begin
            ack     <= 1'b0;  // Single-cycle ack
            pending <= 1'b0;
        end else if (cyc && stb) begin
            if (!pending) begin
                delay = $unsigned($random(seed)) % 4;  // Extra wait cycles, 0 to 3
                pending <= 1'b1;
            end else begin
                delay = waitCnt;
            end
            if (delay == 0) begin
                ack <= 1'b1;
                if (we) begin
                    words[adr[11:2]] <= datW;
                end else begin
                    datR <= words[adr[11:2]];
                end
            end else begin
                waitCnt <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/l2CacheTb.sv
`timescale 1ns/10ps
`include "cache_defs.svh"
`default_nettype none

module l2CacheTb;

    localparam int          ClkPeriod = 4;
    localparam int          NumOps    = 348;  // Sum of all CPU requests below
    localparam logic [31:0] Uncached  = `CACHE_UNCACHED_ADDR;

    localparam logic [2:0] opLb  = 3'b000;
    localparam logic [2:0] opLh  = 3'b001;
    localparam logic [2:0] opLw  = 3'b010;
    localparam logic [2:0] opLbu = 3'b100;
    localparam logic [2:0] opLhu = 3'b101;
    localparam logic [2:0] opSb  = 3'b000;
    localparam logic [2:0] opSh  = 3'b001;
    localparam logic [2:0] opSw  = 3'b010;

    logic        clk;
    logic        rst;
    logic        cpuCyc;
    logic        cpuStb;
    logic        cpuWe;
    logic [31:0] cpuAdr;
    logic [31:0] cpuDatW;
    logic [2:0]  cpuFunct3;
    logic [31:0] cpuDatR;
    logic        cpuAck;
    logic        memCyc;
    logic        memStb;
    logic        memWe;
    logic [31:0] memAdr;
    logic [31:0] memDatW;
    logic [31:0] memDatR;
    logic        memAck;

    logic [7:0]  shadow [0:4095];  // Byte image of what memory should hold
    logic [31:0] expQ [$];         // Expected data of loads in flight
    logic [31:0] expVal;
    logic [31:0] lastWrAdr;
    logic [31:0] lastWrDat;
    integer      seed;
    int          dataErrors  = 0;
    int          checkErrors = 0;
    int          memReads    = 0;
    int          memWrites   = 0;
    int          readsMark;
    int          writesMark;

    l2Cache u_dut (
        .clk(clk), .rst(rst),
        .cpuCyc(cpuCyc), .cpuStb(cpuStb), .cpuWe(cpuWe), .cpuAdr(cpuAdr),
        .cpuDatW(cpuDatW), .cpuFunct3(cpuFunct3), .cpuDatR(cpuDatR), .cpuAck(cpuAck),
        .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memAdr(memAdr),
        .memDatW(memDatW), .memDatR(memDatR), .memAck(memAck)
    );

    wbMemModel u_mem (
        .clk(clk), .rst(rst), .cyc(memCyc), .stb(memStb), .we(memWe),
        .adr(memAdr), .datW(memDatW), .datR(memDatR), .ack(memAck)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] patternWord(input logic [31:0] addr);
        return (addr * 32'h9E3779B1) ^ 32'h6C8E9CF5;  // Same fill as the memory model
    endfunction

    // Expected load result from the shadow bytes
    function automatic logic [31:0] refLoadValue(input logic [31:0] adr, input logic [2:0] f3);
        logic [11:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = adr[11:0];
        b = shadow[a];
        h = {shadow[a + 12'd1], shadow[a]};
        w = {shadow[{a[11:2], 2'b11}], shadow[{a[11:2], 2'b10}],
             shadow[{a[11:2], 2'b01}], shadow[{a[11:2], 2'b00}]};
        case (f3)
            opLb:    return {{24{b[7]}}, b};
            opLbu:   return {24'b0, b};
            opLh:    return {{16{h[15]}}, h};
            opLhu:   return {16'b0, h};
            default: return w;
        endcase
    endfunction

    function automatic void shadowWrite(input logic [31:0] adr, input logic [2:0] f3,
                                        input logic [31:0] data);
        logic [11:0] a;
        a = adr[11:0];
        case (f3[1:0])
            2'b00: shadow[a] = data[7:0];
            2'b01: begin
                shadow[a]         = data[7:0];
                shadow[a + 12'd1] = data[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    shadow[{a[11:2], 2'b00} + k] = data[k*8 +: 8];
                end
            end
        endcase
    endfunction

    // One Wishbone transaction with inputs changed 1 ns after the clock edge
    task automatic busAccess(input logic we, input logic [2:0] f3, input logic [31:0] adr,
                             input logic [31:0] wdat, output int latency);
        int cycles;
        if (we) begin
            shadowWrite(adr, f3, wdat);
        end else begin
            expQ.push_back(refLoadValue(adr, f3));
        end
        @(posedge clk);
        #1;
        cpuCyc    = 1'b1;
        cpuStb    = 1'b1;
        cpuWe     = we;
        cpuAdr    = adr;
        cpuDatW   = wdat;
        cpuFunct3 = f3;
        cycles    = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!cpuAck);
        latency = cycles - 1;  // Edges after the one that sampled stb
        @(posedge clk);
        #1;
        cpuCyc = 1'b0;
        cpuStb = 1'b0;
        cpuWe  = 1'b0;
    endtask

    task automatic load(input logic [2:0] f3, input logic [31:0] adr);
        int lat;
        busAccess(1'b0, f3, adr, '0, lat);
    endtask

    task automatic store(input logic [2:0] f3, input logic [31:0] adr, input logic [31:0] data);
        int lat;
        busAccess(1'b1, f3, adr, data, lat);
    endtask

    task automatic readEveryWidth(input logic [31:0] base);
        for (int off = 0; off < 4; off++) begin
            load(opLb, base + off);
            load(opLbu, base + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            load(opLh, base + off);
            load(opLhu, base + off);
        end
        load(opLw, base);
    endtask

    task automatic markTransfers();
        readsMark  = memReads;
        writesMark = memWrites;
    endtask

    task automatic verifyTransfers(input int expR, input int expW, input string what);
        int dr;
        int dw;
        dr = memReads - readsMark;
        dw = memWrites - writesMark;
        assert (dr == expR) else begin
            checkErrors++;
            $display("FAIL %0t ns memory reads (%s) got %0d expected %0d", $time, what, dr, expR);
        end
        assert (dw == expW) else begin
            checkErrors++;
            $display("FAIL %0t ns memory writes (%s) got %0d expected %0d",
                     $time, what, dw, expW);
        end
    endtask

    // Memory-side transfer monitor
    always @(posedge clk) begin
        if (memCyc && memStb && memAck) begin
            if (memWe) begin
                memWrites++;
                lastWrAdr = memAdr;
                lastWrDat = memDatW;
            end else begin
                memReads++;
            end
        end
    end

    // Load data check at mid-cycle while cpuAck is high
    always @(negedge clk) begin
        if (cpuAck && !cpuWe) begin
            assert (expQ.size() != 0) else begin
                checkErrors++;
                $display("cpuAck for a load at %0t ns with no expected value queued", $time);
            end
            if (expQ.size() != 0) begin
                expVal = expQ.pop_front();
                assert (cpuDatR === expVal) else begin
                    dataErrors++;
                    $display("FAIL %0t ns cpuDatR (adr %h funct3 %0d) got %h expected %h",
                             $time, cpuAdr, cpuFunct3, cpuDatR, expVal);
                end
            end
        end
    end

    initial begin
        #(NumOps * 20 * ClkPeriod);
        $display("Simulation timed out after %0d ns", NumOps * 20 * ClkPeriod);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] adr;
        logic [31:0] data;
        logic [2:0]  f3;
        logic        we;
        int          lat;
        int          word;
        int          sel;
        int          pos;
        int          off;
        seed      = 32'h1ab4466f;
        rst       = 1'b1;
        cpuCyc    = 1'b0;
        cpuStb    = 1'b0;
        cpuWe     = 1'b0;
        cpuAdr    = '0;
        cpuDatW   = '0;
        cpuFunct3 = '0;
        for (int i = 0; i < 1024; i++) begin
            w = patternWord(i * 4);
            for (int k = 0; k < 4; k++) begin
                shadow[i*4 + k] = w[k*8 +: 8];
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Miss then hit
        markTransfers();
        busAccess(1'b0, opLw, 32'h104, '0, lat);
        verifyTransfers(1, 0, "first lw");
        markTransfers();
        busAccess(1'b0, opLw, 32'h104, '0, lat);
        verifyTransfers(0, 0, "repeated lw");
        assert (lat == 3) else begin
            checkErrors++;
            $display("FAIL %0t ns cpuAck latency got %0d expected 3", $time, lat);
        end

        // Sub-word stores at every offset
        for (int i = 0; i < 4; i++) begin
            store(opSb, 32'h20 + i, 32'h7F + i * 32'h2B);
        end
        readEveryWidth(32'h20);
        store(opSh, 32'h20, 32'h0000_8421);
        store(opSh, 32'h22, 32'h1234_7FFE);
        readEveryWidth(32'h20);

        // Dirty victim in set 5 written back when C arrives
        store(opSw, 32'h214, 32'h5EED_1234);
        load(opLw, 32'h234);
        markTransfers();
        load(opLw, 32'h254);
        verifyTransfers(1, 1, "eviction of dirty line");
        assert (lastWrAdr == 32'h214) else begin
            checkErrors++;
            $display("FAIL %0t ns memAdr got %h expected %h", $time, lastWrAdr, 32'h214);
        end
        assert (lastWrDat == refLoadValue(32'h214, opLw)) else begin
            checkErrors++;
            $display("FAIL %0t ns memDatW got %h expected %h",
                     $time, lastWrDat, refLoadValue(32'h214, opLw));
        end
        markTransfers();
        load(opLw, 32'h214);
        verifyTransfers(1, 0, "reload of evicted line");

        // LRU order in set 6
        load(opLw, 32'h318);
        load(opLw, 32'h338);
        load(opLw, 32'h318);
        load(opLw, 32'h358);
        markTransfers();
        load(opLw, 32'h318);
        verifyTransfers(0, 0, "most recent way kept");
        markTransfers();
        load(opLw, 32'h338);
        verifyTransfers(1, 0, "LRU way replaced");

        // Uncached word always reaches memory
        markTransfers();
        load(opLw, Uncached);
        verifyTransfers(1, 0, "uncached lw");
        markTransfers();
        load(opLw, Uncached);
        verifyTransfers(1, 0, "repeated uncached lw");
        markTransfers();
        store(opSw, Uncached, 32'hC0DE_F00D);
        verifyTransfers(0, 1, "uncached sw");
        markTransfers();
        load(opLw, Uncached);
        verifyTransfers(1, 0, "uncached lw after sw");

        // Random mix over 64 words starting at 0x100
        for (int i = 0; i < 300; i++) begin
            word = $unsigned($random(seed)) % 64;
            sel  = $unsigned($random(seed)) % 8;
            pos  = $unsigned($random(seed)) % 4;
            data = $random(seed);
            we   = (sel >= 5);
            f3   = (sel < 3) ? sel : (sel < 5) ? sel + 1 : sel - 5;  // Skip funct3 3
            case (f3[1:0])
                2'b00:   off = pos;
                2'b01:   off = pos & 2;
                default: off = 0;
            endcase
            adr = 32'h100 + word * 4 + off;
            busAccess(we, f3, adr, data, lat);
        end

        assert (expQ.size() == 0) else begin
            checkErrors++;
            $display("%0d loads never received cpuAck", expQ.size());
        end
        $display("Finished with %0d data errors and %0d other errors", dataErrors, checkErrors);
        if (dataErrors + checkErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/cachePkg.sv
verilog/cacheReqDecode.sv
verilog/cacheWayArray.sv
verilog/cacheLoadFormat.sv
verilog/l2Cache.sv
verif/wbMemModel.sv
verif/l2CacheTb.sv

//--- Bender.yml
package:
  name: l2_cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cachePkg.sv
      - verilog/cacheReqDecode.sv
      - verilog/cacheWayArray.sv
      - verilog/cacheLoadFormat.sv
      - verilog/l2Cache.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/wbMemModel.sv
      - verif/l2CacheTb.sv
